//--- rtl/gf4_pkg.sv
package gf4_pkg;

  ////////////////////////////////////////////////////////////
  // array geometry

  localparam int N_ROWS = 4;
  localparam int N_COLS = 4;
  localparam int ELEM_W = 2;

  // start to result_valid, in cycles
  localparam int LATENCY = 9;

  ////////////////////////////////////////////////////////////
  // element and command types

  typedef logic [ELEM_W-1:0] gf4_t;

  // column 0 sits in the low bits
  typedef gf4_t [N_COLS-1:0] gf4_vec_t;

  typedef enum logic [1:0] {
    op_pass  = 2'd0,
    op_load  = 2'd1,
    op_scale = 2'd2,
    op_elim  = 2'd3
  } row_op_e;

  typedef struct packed {
    gf4_t    fac;
    row_op_e op;
  } row_cmd_t;

  // row 0 sits in the low bits
  typedef row_cmd_t [N_ROWS-1:0] cmd_bus_t;

  typedef struct packed {
    logic     valid;
    row_cmd_t cmd;
  } lane_t;

  ////////////////////////////////////////////////////////////
  // arithmetic

  // elements are polynomials in alpha, reduced with alpha^2 = alpha + 1
  function automatic gf4_t gf4_mul(input gf4_t a, input gf4_t b);
    logic top;
    top = a[1] & b[1];
    return {top ^ (a[1] & b[0]) ^ (a[0] & b[1]), top ^ (a[0] & b[0])};
  endfunction

endpackage

//--- rtl/row_cmd_decode.sv
module row_cmd_decode
  import gf4_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  gf4_vec_t data,
  input  cmd_bus_t cmds,
  output lane_t    row_lanes [N_ROWS],
  output gf4_t     col_data  [N_COLS]
);

  logic     start_q;
  gf4_vec_t data_q;
  cmd_bus_t cmds_q;

  // input register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= data;
    cmds_q <= cmds;
  end

  ////////////////////////////////////////////////////////////
  // row r command, r cycles late

  for (genvar r = 0; r < N_ROWS; r++) begin : g_row
    if (r == 0) begin : g_direct
      assign row_lanes[r] = '{valid: start_q, cmd: cmds_q[r]};
    end else begin : g_delay
      logic     vld_d [r];
      row_cmd_t cmd_d [r];

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          for (int s = 0; s < r; s++) begin
            vld_d[s] <= 1'b0;
          end
        end else begin
          vld_d[0] <= start_q;
          for (int s = 1; s < r; s++) begin
            vld_d[s] <= vld_d[s-1];
          end
        end
      end

      always_ff @(posedge clk) begin
        cmd_d[0] <= cmds_q[r];
        for (int s = 1; s < r; s++) begin
          cmd_d[s] <= cmd_d[s-1];
        end
      end

      assign row_lanes[r] = '{valid: vld_d[r-1], cmd: cmd_d[r-1]};
    end
  end

  ////////////////////////////////////////////////////////////
  // column c data, c cycles late

  for (genvar c = 0; c < N_COLS; c++) begin : g_col
    if (c == 0) begin : g_direct
      assign col_data[c] = data_q[c];
    end else begin : g_delay
      gf4_t elem_d [c];

      always_ff @(posedge clk) begin
        elem_d[0] <= data_q[c];
        for (int s = 1; s < c; s++) begin
          elem_d[s] <= elem_d[s-1];
        end
      end

      assign col_data[c] = elem_d[c-1];
    end
  end

endmodule

//--- rtl/gf4_cell.sv
module gf4_cell
  import gf4_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  lane_t lane_in,
  input  gf4_t  data_in,
  output lane_t lane_out,
  output gf4_t  data_out
);

  gf4_t     pivot;
  gf4_t     data_nxt;
  logic     valid_q;
  row_cmd_t cmd_q;

  // row operation on the element passing down
  always_comb begin
    data_nxt = data_in;
    if (lane_in.valid) begin
      case (lane_in.cmd.op)
        op_scale: data_nxt = gf4_mul(lane_in.cmd.fac, data_in);
        op_elim:  data_nxt = data_in ^ gf4_mul(lane_in.cmd.fac, pivot);
        default:  data_nxt = data_in;
      endcase
    end
  end

  // held pivot, replaced only by a valid load
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pivot <= '0;
    end else if (lane_in.valid && lane_in.cmd.op == op_load) begin
      pivot <= data_in;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= lane_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    cmd_q    <= lane_in.cmd;
    data_out <= data_nxt;
  end

  // command moves on to the right neighbour
  assign lane_out = '{valid: valid_q, cmd: cmd_q};

endmodule

//--- rtl/elim_array.sv
module elim_array
  import gf4_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  lane_t row_lanes    [N_ROWS],
  input  gf4_t  col_data     [N_COLS],
  output gf4_t  bottom_data  [N_COLS],
  output logic  bottom_valid [N_COLS]
);

  // lane_h[r][c] enters cell (r,c) from the left
  lane_t lane_h [N_ROWS][N_COLS+1];
  // data_v[r][c] enters cell (r,c) from above
  gf4_t  data_v [N_ROWS+1][N_COLS];

  ////////////////////////////////////////////////////////////
  // array edges

  for (genvar r = 0; r < N_ROWS; r++) begin : g_left
    assign lane_h[r][0] = row_lanes[r];
  end

  for (genvar c = 0; c < N_COLS; c++) begin : g_edge
    assign data_v[0][c] = col_data[c];

    // bottom row registers lane and data in the same cycle
    assign bottom_data[c]  = data_v[N_ROWS][c];
    assign bottom_valid[c] = lane_h[N_ROWS-1][c+1].valid;
  end

  ////////////////////////////////////////////////////////////
  // cell grid

  for (genvar r = 0; r < N_ROWS; r++) begin : g_r
    for (genvar c = 0; c < N_COLS; c++) begin : g_c
      gf4_cell i_cell (
        .clk      (clk),
        .rst_n    (rst_n),
        .lane_in  (lane_h[r][c]),
        .data_in  (data_v[r][c]),
        .lane_out (lane_h[r][c+1]),
        .data_out (data_v[r+1][c])
      );
    end
  end

endmodule

//--- rtl/result_align.sv
module result_align
  import gf4_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  gf4_t     bottom_data  [N_COLS],
  input  logic     bottom_valid [N_COLS],
  output gf4_vec_t result,
  output logic     result_valid
);

  gf4_t al_data  [N_COLS];
  logic al_valid [N_COLS];

  // column c waits for the last column, N_COLS-1-c cycles
  for (genvar c = 0; c < N_COLS; c++) begin : g_col
    localparam int D = N_COLS - 1 - c;

    if (D == 0) begin : g_direct
      assign al_data[c]  = bottom_data[c];
      assign al_valid[c] = bottom_valid[c];
    end else begin : g_delay
      gf4_t elem_d [D];
      logic vld_d  [D];

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          for (int s = 0; s < D; s++) begin
            vld_d[s] <= 1'b0;
          end
        end else begin
          vld_d[0] <= bottom_valid[c];
          for (int s = 1; s < D; s++) begin
            vld_d[s] <= vld_d[s-1];
          end
        end
      end

      always_ff @(posedge clk) begin
        elem_d[0] <= bottom_data[c];
        for (int s = 1; s < D; s++) begin
          elem_d[s] <= elem_d[s-1];
        end
      end

      assign al_data[c]  = elem_d[D-1];
      assign al_valid[c] = vld_d[D-1];
    end

    // each element updates only with its own wavefront
    always_ff @(posedge clk) begin
      if (al_valid[c]) begin
        result[c] <= al_data[c];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= al_valid[N_COLS-1];
    end
  end

endmodule

//--- rtl/gf4_elim_top.sv
module gf4_elim_top
  import gf4_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     start,
  input  gf4_vec_t data,
  input  cmd_bus_t cmds,
  output gf4_vec_t result,
  output logic     result_valid
);

  lane_t row_lanes    [N_ROWS];
  gf4_t  col_data     [N_COLS];
  gf4_t  bottom_data  [N_COLS];
  logic  bottom_valid [N_COLS];

  row_cmd_decode i_decode (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .data      (data),
    .cmds      (cmds),
    .row_lanes (row_lanes),
    .col_data  (col_data)
  );

  elim_array i_array (
    .clk          (clk),
    .rst_n        (rst_n),
    .row_lanes    (row_lanes),
    .col_data     (col_data),
    .bottom_data  (bottom_data),
    .bottom_valid (bottom_valid)
  );

  result_align i_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .bottom_data  (bottom_data),
    .bottom_valid (bottom_valid),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

//--- tests/gf4_elim_chk.sv
module gf4_elim_chk
  import gf4_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     start,
  input gf4_vec_t result,
  input logic     result_valid
);

  timeunit 1ns;
  timeprecision 100ps;

  // edges since reset release, saturating once start history is full
  int settle;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      settle <= 0;
    end else if (settle < LATENCY) begin
      settle <= settle + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // output protocol

  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    settle == LATENCY |-> result_valid == $past(start, LATENCY))
    else $error("result_valid does not follow start by the fixed latency");

  a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |=> !result_valid)
    else $error("result_valid high in the cycle after reset release");

  a_known: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> !$isunknown(result))
    else $error("result has unknown bits while result_valid is high");

endmodule

bind gf4_elim_top gf4_elim_chk i_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .start        (start),
  .result       (result),
  .result_valid (result_valid)
);

//--- tests/tb_gf4_elim.sv
module tb_gf4_elim
  import gf4_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic     clk;
  logic     rst_n;
  logic     start;
  gf4_vec_t data;
  cmd_bus_t cmds;
  gf4_vec_t result;
  logic     result_valid;

  // reference model state
  gf4_t     mul_tab [4][4];
  gf4_t     pivots  [N_ROWS][N_COLS];
  gf4_vec_t exp_q   [$];
  int       due_q   [$];
  int       cycle;
  integer   seed;

  gf4_elim_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .data         (data),
    .cmds         (cmds),
    .result       (result),
    .result_valid (result_valid)
  );

  always #4 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // tests take about 370 cycles, so 2000 leaves a wide margin
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= 2000) begin
      fail_run("timeout: run did not finish within 2000 cycles");
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model

  task automatic build_mul_table();
    for (int a = 0; a < 4; a++) begin
      for (int b = 0; b < 4; b++) begin
        mul_tab[a][b] = '0;
      end
    end
    // 1 is the identity, 0 absorbs
    for (int a = 1; a < 4; a++) begin
      mul_tab[1][a] = gf4_t'(a);
      mul_tab[a][1] = gf4_t'(a);
    end
    // alpha squared is alpha+1
    mul_tab[2][2] = 2'd3;
    mul_tab[2][3] = 2'd1;
    mul_tab[3][2] = 2'd1;
    mul_tab[3][3] = 2'd2;
  endtask

  function automatic gf4_vec_t model_apply(input gf4_vec_t v, input cmd_bus_t c);
    gf4_vec_t x;
    x = v;
    for (int r = 0; r < N_ROWS; r++) begin
      for (int k = 0; k < N_COLS; k++) begin
        case (c[r].op)
          op_load:  pivots[r][k] = x[k];
          op_scale: x[k] = mul_tab[c[r].fac][x[k]];
          op_elim:  x[k] = x[k] ^ mul_tab[c[r].fac][pivots[r][k]];
          default:  x[k] = x[k];
        endcase
      end
    end
    return x;
  endfunction

  function automatic cmd_bus_t row0_cmds(input row_op_e op, input gf4_t fac);
    cmd_bus_t c;
    c = '0;
    c[0].op  = op;
    c[0].fac = fac;
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus and result checking

  task automatic send_vector(input gf4_vec_t v, input cmd_bus_t c);
    @(posedge clk);
    #1;
    start = 1'b1;
    data  = v;
    cmds  = c;
    exp_q.push_back(model_apply(v, c));
    due_q.push_back(cycle + LATENCY);
  endtask

  task automatic send_idle(input gf4_vec_t v, input cmd_bus_t c);
    @(posedge clk);
    #1;
    start = 1'b0;
    data  = v;
    cmds  = c;
  endtask

  task automatic drain_results();
    send_idle('0, '0);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  always @(negedge clk) begin
    gf4_vec_t want;
    int       due;
    if (rst_n && result_valid) begin
      if (exp_q.size() == 0) begin
        fail_run("result_valid went high with no result outstanding");
      end else begin
        want = exp_q.pop_front();
        due  = due_q.pop_front();
        assert (cycle == due)
          else fail_run($sformatf("result came in cycle %0d instead of %0d", cycle, due));
        assert (result === want)
          else fail_run($sformatf("FAILED result: expected %h, got %h", want, result));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // directed tests

  task automatic check_idle();
    repeat (12) begin
      @(negedge clk);
      assert (result_valid === 1'b0)
        else fail_run($sformatf("FAILED result_valid: expected 0, got %h", result_valid));
    end
  endtask

  task automatic run_pass_test();
    logic [31:0] rnd;
    cmd_bus_t    c;
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      c   = '0;
      // factor must not matter for a pass
      for (int r = 0; r < N_ROWS; r++) begin
        c[r].fac = rnd[2*r+9 -: 2];
      end
      send_vector(rnd[7:0], c);
    end
    drain_results();
  endtask

  task automatic run_scale_test();
    logic [31:0] rnd;
    cmd_bus_t    c;
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      for (int r = 0; r < N_ROWS; r++) begin
        c[r].op  = op_scale;
        c[r].fac = gf4_t'((i >> (2 * (r % 2))) + r / 2);
      end
      send_vector(rnd[7:0], c);
    end
    drain_results();
  endtask

  task automatic run_load_elim_test();
    logic [31:0] rnd;
    for (int f = 0; f < 4; f++) begin
      rnd = $random(seed);
      send_vector(rnd[7:0], row0_cmds(op_load, 2'd0));
      // loads with start low must leave the pivots alone
      send_idle(rnd[15:8], row0_cmds(op_load, 2'd1));
      send_idle(rnd[23:16], {N_ROWS{2'd0, op_load}});
      send_vector(rnd[31:24], row0_cmds(op_elim, gf4_t'(f)));
    end
    drain_results();
  endtask

  task automatic run_stream_test();
    logic [31:0] rnd;
    for (int i = 0; i < 250; i++) begin
      rnd = $random(seed);
      send_vector(rnd[7:0], rnd[31:16]);
    end
    drain_results();
  endtask

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    data  = '0;
    cmds  = '0;
    cycle = 0;
    seed  = 32'h2a69;
    build_mul_table();
    for (int r = 0; r < N_ROWS; r++) begin
      for (int k = 0; k < N_COLS; k++) begin
        pivots[r][k] = '0;
      end
    end

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    check_idle();
    run_pass_test();
    run_scale_test();
    run_load_elim_test();
    run_stream_test();

    repeat (LATENCY + 2) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      fail_run("results still outstanding at end of run");
    end
  end

endmodule

//--- src.f
rtl/gf4_pkg.sv
rtl/row_cmd_decode.sv
rtl/gf4_cell.sv
rtl/elim_array.sv
rtl/result_align.sv
rtl/gf4_elim_top.sv
tests/gf4_elim_chk.sv
tests/tb_gf4_elim.sv

//--- Makefile
TOP := tb_gf4_elim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timing -f src.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
